// ==== verilog/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// request address is a byte address, cache works on 32-bit words
`define CACHE_ADDR_WIDTH 16   // byte address width
`define CACHE_DATA_WIDTH 32   // word width

// address split, low to high: byte offset, set index, tag
`define CACHE_BYTE_BITS 2     // byte offset within a word
`define CACHE_SET_BITS 4      // 16 sets per way
`define CACHE_TAG_BITS 10     // everything above the set index

`define CACHE_NUM_SETS (1 << `CACHE_SET_BITS)

// backing store depth, one entry per word address
`define CACHE_MEM_WORDS 16384

`endif

// ==== verilog/cache_types_pkg.sv ====
`default_nettype none

`include "cache_consts.svh"

package cache_types_pkg;

    typedef logic [`CACHE_TAG_BITS-1:0] tag_t;        // stored and compared tag
    typedef logic [`CACHE_SET_BITS-1:0] set_idx_t;    // row select in each way
    typedef logic [`CACHE_DATA_WIDTH-1:0] data_word_t; // one line is one word

    // tag field of a byte address
    function automatic tag_t addr_tag(input logic [`CACHE_ADDR_WIDTH-1:0] addr);
        addr_tag = addr[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_BITS];
    endfunction

    // set field sits right above the byte offset
    function automatic set_idx_t addr_set(input logic [`CACHE_ADDR_WIDTH-1:0] addr);
        addr_set = addr[`CACHE_BYTE_BITS +: `CACHE_SET_BITS];
    endfunction

endpackage

`default_nettype wire

// ==== verilog/mem_pkg.sv ====
`default_nettype none

`include "cache_consts.svh"

package mem_pkg;

    typedef logic [`CACHE_ADDR_WIDTH-1:0] byte_addr_t;                   // request address
    typedef logic [`CACHE_ADDR_WIDTH-`CACHE_BYTE_BITS-1:0] word_addr_t;  // drops byte bits
    typedef logic [`CACHE_DATA_WIDTH-1:0] mem_word_t;

    function automatic word_addr_t to_word_addr(input byte_addr_t addr);
        to_word_addr = addr[`CACHE_ADDR_WIDTH-1:`CACHE_BYTE_BITS];
    endfunction

endpackage

`default_nettype wire

// ==== verilog/set_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

// one entry per set, read is async so the lookup finishes in the request cycle
module set_ram #(
    parameter type entry_t = logic [`CACHE_DATA_WIDTH-1:0]
) (
    input  logic                       clk,
    input  logic [`CACHE_SET_BITS-1:0] rd_set,
    output entry_t                     rd_entry,
    input  logic                       wr_en,
    input  logic [`CACHE_SET_BITS-1:0] wr_set,
    input  entry_t                     wr_entry
);

    entry_t mem [`CACHE_NUM_SETS];

    assign rd_entry = mem[rd_set];   // combinational lookup

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_set] <= wr_entry;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cache_way.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module cache_way
    import cache_types_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  set_idx_t   set_idx,
    input  tag_t       req_tag,
    output logic       match,
    output logic       dirty,
    output tag_t       stored_tag,
    output data_word_t stored_data,
    input  logic       wr_en,
    input  tag_t       wr_tag,
    input  data_word_t wr_data,
    input  logic       wr_dirty
);

    logic [`CACHE_NUM_SETS-1:0] valid_q;
    logic [`CACHE_NUM_SETS-1:0] dirty_q;
    logic                       set_valid;

    set_ram #(
        .entry_t (tag_t)
    ) tag_ram (
        .clk      (clk),
        .rd_set   (set_idx),
        .rd_entry (stored_tag),
        .wr_en    (wr_en),
        .wr_set   (set_idx),
        .wr_entry (wr_tag)
    );

    set_ram #(
        .entry_t (data_word_t)
    ) data_ram (
        .clk      (clk),
        .rd_set   (set_idx),
        .rd_entry (stored_data),
        .wr_en    (wr_en),
        .wr_set   (set_idx),
        .wr_entry (wr_data)
    );

    // state bits live outside the rams so reset can clear them
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            valid_q[set_idx] <= 1'b1;      // any write installs the line
            dirty_q[set_idx] <= wr_dirty;
        end
    end

    assign set_valid = valid_q[set_idx];

    // stale tag/dirty of an empty set must not leak out
    assign match = set_valid && (stored_tag == req_tag);
    assign dirty = set_valid && dirty_q[set_idx];

endmodule

`default_nettype wire

// ==== verilog/cache_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module cache_controller
    import cache_types_pkg::*;
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req,
    input  logic       we,
    input  byte_addr_t addr,
    input  data_word_t wdata,
    input  logic       match0,
    input  logic       match1,
    input  logic       dirty0,
    input  logic       dirty1,
    input  tag_t       tag0,
    input  tag_t       tag1,
    input  data_word_t data0,
    input  data_word_t data1,
    input  mem_word_t  mem_rdata,
    output logic       way0_wr,
    output logic       way1_wr,
    output tag_t       wr_tag,
    output data_word_t wr_data,
    output logic       wr_dirty,
    output logic       mem_we,
    output word_addr_t mem_waddr,
    output mem_word_t  mem_wdata,
    output logic       resp_valid,
    output logic       resp_hit,
    output data_word_t rdata
);

    logic [`CACHE_NUM_SETS-1:0] lru_q;   // per set: index of the least recent way
    set_idx_t                   set_idx;
    logic                       hit;
    logic                       hit_way;
    logic                       victim;
    logic                       sel_way;
    logic                       way_wr;
    logic                       victim_dirty;
    tag_t                       victim_tag;
    data_word_t                 hit_data;
    data_word_t                 victim_data;

    assign set_idx = addr_set(addr);

    assign hit     = match0 || match1;
    assign hit_way = match1;             // tags never repeat inside a set
    assign victim  = lru_q[set_idx];     // cleared lru picks way 0 first
    assign sel_way = hit ? hit_way : victim;

    assign hit_data     = hit_way ? data1 : data0;
    assign victim_tag   = victim ? tag1 : tag0;
    assign victim_data  = victim ? data1 : data0;
    assign victim_dirty = victim ? dirty1 : dirty0;

    // read hit leaves the way alone, everything else writes the selected way
    assign way_wr   = req && (we || !hit);
    assign way0_wr  = way_wr && !sel_way;
    assign way1_wr  = way_wr && sel_way;
    assign wr_tag   = addr_tag(addr);
    assign wr_data  = we ? wdata : mem_rdata;
    assign wr_dirty = we;

    // write-back of a dirty victim shares the edge with the refill
    assign mem_we    = req && !hit && victim_dirty;
    assign mem_waddr = {victim_tag, set_idx};
    assign mem_wdata = victim_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q      <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req;
            if (req) begin
                lru_q[set_idx] <= !sel_way;   // the other way becomes least recent
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            resp_hit <= hit;
            if (we) begin
                rdata <= wdata;
            end else begin
                rdata <= hit ? hit_data : mem_rdata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/main_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

// backing store behind the cache, no latency on either port
module main_memory
    import mem_pkg::*;
(
    input  logic       clk,
    input  word_addr_t rd_addr,
    output mem_word_t  rd_data,
    input  logic       wr_en,
    input  word_addr_t wr_addr,
    input  mem_word_t  wr_data
);

    mem_word_t mem [`CACHE_MEM_WORDS];

    // whole array starts at zero so a cold read is predictable
    initial begin
        for (int i = 0; i < `CACHE_MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign rd_data = mem[rd_addr];   // async read for the refill path

    always @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;   // victim write-back
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_top
    import cache_types_pkg::*;
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req,
    input  logic       we,
    input  byte_addr_t addr,
    input  data_word_t wdata,
    output logic       resp_valid,
    output logic       resp_hit,
    output data_word_t rdata
);

    logic       match0;
    logic       match1;
    logic       dirty0;
    logic       dirty1;
    tag_t       tag0;
    tag_t       tag1;
    data_word_t data0;
    data_word_t data1;
    logic       way0_wr;
    logic       way1_wr;
    tag_t       wr_tag;
    data_word_t wr_data;
    logic       wr_dirty;
    logic       mem_we;
    word_addr_t mem_waddr;
    mem_word_t  mem_wdata;
    mem_word_t  mem_rdata;

    cache_way way0 (
        .clk         (clk),
        .reset       (reset),
        .set_idx     (addr_set(addr)),
        .req_tag     (addr_tag(addr)),
        .match       (match0),
        .dirty       (dirty0),
        .stored_tag  (tag0),
        .stored_data (data0),
        .wr_en       (way0_wr),
        .wr_tag      (wr_tag),
        .wr_data     (wr_data),
        .wr_dirty    (wr_dirty)
    );

    cache_way way1 (
        .clk         (clk),
        .reset       (reset),
        .set_idx     (addr_set(addr)),
        .req_tag     (addr_tag(addr)),
        .match       (match1),
        .dirty       (dirty1),
        .stored_tag  (tag1),
        .stored_data (data1),
        .wr_en       (way1_wr),
        .wr_tag      (wr_tag),
        .wr_data     (wr_data),
        .wr_dirty    (wr_dirty)
    );

    cache_controller ctrl (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .we         (we),
        .addr       (addr),
        .wdata      (wdata),
        .match0     (match0),
        .match1     (match1),
        .dirty0     (dirty0),
        .dirty1     (dirty1),
        .tag0       (tag0),
        .tag1       (tag1),
        .data0      (data0),
        .data1      (data1),
        .mem_rdata  (mem_rdata),
        .way0_wr    (way0_wr),
        .way1_wr    (way1_wr),
        .wr_tag     (wr_tag),
        .wr_data    (wr_data),
        .wr_dirty   (wr_dirty),
        .mem_we     (mem_we),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .resp_valid (resp_valid),
        .resp_hit   (resp_hit),
        .rdata      (rdata)
    );

    main_memory mem (
        .clk     (clk),
        .rd_addr (to_word_addr(addr)),   // refill always reads the request word
        .rd_data (mem_rdata),
        .wr_en   (mem_we),
        .wr_addr (mem_waddr),
        .wr_data (mem_wdata)
    );

endmodule

`default_nettype wire

// ==== verification/cache_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module cache_tb
    import cache_types_pkg::*;
    import mem_pkg::*;
();

    localparam int RESET_CYCLES   = 10;
    localparam int NUM_DIRECTED   = 14;
    localparam int NUM_RANDOM     = 2000;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * (NUM_DIRECTED + NUM_RANDOM) + 100;

    logic       clk;
    logic       reset;
    logic       req;
    logic       we;
    byte_addr_t addr;
    data_word_t wdata;
    logic       resp_valid;
    logic       resp_hit;
    data_word_t rdata;

    // reference model state
    tag_t       ref_tag   [2][`CACHE_NUM_SETS];
    data_word_t ref_data  [2][`CACHE_NUM_SETS];
    logic       ref_valid [2][`CACHE_NUM_SETS];
    logic       ref_dirty [2][`CACHE_NUM_SETS];
    logic       ref_lru   [`CACHE_NUM_SETS];      // index of least recent way
    mem_word_t  ref_mem   [`CACHE_MEM_WORDS];

    logic       exp_hit_q[$];
    data_word_t exp_data_q[$];
    logic       req_seen = 1'b0;                  // req sampled at the last edge
    int         cycles = 0;
    int         checks = 0;
    int         value_errs = 0;
    int         proto_errs = 0;
    integer     seed;

    cache_top UUT (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .we         (we),
        .addr       (addr),
        .wdata      (wdata),
        .resp_valid (resp_valid),
        .resp_hit   (resp_hit),
        .rdata      (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // runs one request through the model and returns the expected response
    function automatic void model_access(
        input  logic       wr,
        input  byte_addr_t a,
        input  data_word_t d,
        output logic       hit,
        output data_word_t data
    );
        set_idx_t set_i;
        tag_t     tag;
        int       way;
        set_i = a[`CACHE_SET_BITS+1:2];
        tag   = a[`CACHE_ADDR_WIDTH-1:`CACHE_SET_BITS+2];
        hit   = 1'b0;
        way   = ref_lru[set_i];
        for (int i = 0; i < 2; i++) begin
            if (ref_valid[i][set_i] && ref_tag[i][set_i] == tag) begin
                hit = 1'b1;
                way = i;
            end
        end
        if (!hit && ref_valid[way][set_i] && ref_dirty[way][set_i]) begin
            ref_mem[{ref_tag[way][set_i], set_i}] = ref_data[way][set_i];   // write-back
        end
        if (wr) begin
            ref_data[way][set_i]  = d;
            ref_dirty[way][set_i] = 1'b1;
            data = d;
        end else if (!hit) begin
            ref_data[way][set_i]  = ref_mem[a[`CACHE_ADDR_WIDTH-1:2]];   // clean refill
            ref_dirty[way][set_i] = 1'b0;
            data = ref_data[way][set_i];
        end else begin
            data = ref_data[way][set_i];
        end
        ref_tag[way][set_i]   = tag;
        ref_valid[way][set_i] = 1'b1;
        ref_lru[set_i]        = (way == 0);   // other way is now least recent
    endfunction

    // want_hit of -1 leaves the expected hit to the model
    task automatic issue_request(input logic wr, input byte_addr_t a, input data_word_t d,
                                 input int want_hit);
        logic       hit;
        data_word_t data;
        model_access(wr, a, d, hit, data);
        if (want_hit >= 0) begin
            hit = want_hit[0];   // hit or miss the scenario is built to produce
        end
        exp_hit_q.push_back(hit);
        exp_data_q.push_back(data);
        @(posedge clk);
        req   <= 1'b1;
        we    <= wr;
        addr  <= a;
        wdata <= d;
    endtask

    task automatic go_idle();
        @(posedge clk);
        req <= 1'b0;
        we  <= 1'b0;
    endtask

    always @(posedge clk) begin
        req_seen <= req && !reset;
    end

    // responses settle after the rising edge and hold through the falling edge
    always @(negedge clk) begin
        logic       eh;
        data_word_t ed;
        if (!reset) begin
            assert (resp_valid === req_seen) else begin
                proto_errs++;
                if (req_seen) begin
                    $display("%0t: request was accepted but no response came", $time);
                end else begin
                    $display("%0t: response came without a request", $time);
                end
            end
            if (req_seen && exp_hit_q.size() != 0) begin
                eh = exp_hit_q.pop_front();
                ed = exp_data_q.pop_front();
                if (resp_valid === 1'b1) begin
                    checks++;
                    assert (resp_hit === eh) else begin
                        value_errs++;
                        $display("ERR %0t resp_hit expected %0b got %0b", $time, eh, resp_hit);
                    end
                    assert (rdata === ed) else begin
                        value_errs++;
                        $display("ERR %0t rdata expected %h got %h", $time, ed, rdata);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        byte_addr_t a;
        data_word_t r;
        reset = 1'b1;
        req   = 1'b0;
        we    = 1'b0;
        addr  = '0;
        wdata = '0;
        seed  = 32'h6b23;
        for (int i = 0; i < `CACHE_NUM_SETS; i++) begin
            ref_lru[i] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                ref_tag[w][i]   = '0;
                ref_data[w][i]  = '0;
                ref_valid[w][i] = 1'b0;
                ref_dirty[w][i] = 1'b0;
            end
        end
        for (int i = 0; i < `CACHE_MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // cold reads miss and return zero
        issue_request(1'b0, 16'h0000, '0, 0);
        issue_request(1'b0, 16'h3ffc, '0, 0);

        // write then read back in set 2
        issue_request(1'b1, 16'h0108, 32'hcafe_f00d, 0);
        issue_request(1'b0, 16'h0108, '0, 1);

        // A B A C in set 3 where C replaces B
        issue_request(1'b0, 16'h004c, '0, 0);
        issue_request(1'b0, 16'h008c, '0, 0);
        issue_request(1'b0, 16'h004c, '0, 1);
        issue_request(1'b0, 16'h00cc, '0, 0);
        issue_request(1'b0, 16'h004c, '0, 1);
        issue_request(1'b0, 16'h008c, '0, 0);

        // dirty A pushed out by C in set 5 and read back from memory
        issue_request(1'b1, 16'h0054, 32'h1111_aaaa, 0);
        issue_request(1'b1, 16'h0094, 32'h2222_bbbb, 0);
        issue_request(1'b0, 16'h00d4, '0, 0);
        issue_request(1'b0, 16'h0054, '0, 0);

        // back to back traffic over 64 words with random byte offset bits
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r = $random(seed);
            a = {8'h00, r[5:0], r[7:6]};
            issue_request(r[8], a, $random(seed), -1);
        end
        go_idle();

        while (exp_hit_q.size() != 0) @(negedge clk);
        @(negedge clk);
        @(posedge clk);

        $display("checked %0d responses: %0d value errors, %0d protocol errors",
                 checks, value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0 && checks != 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verilog
verilog/cache_types_pkg.sv
verilog/mem_pkg.sv
verilog/set_ram.sv
verilog/cache_way.sv
verilog/cache_controller.sv
verilog/main_memory.sv
verilog/cache_top.sv
verification/cache_tb.sv

// ==== Bender.yml ====
package:
  name: two_way_cache

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cache_types_pkg.sv
      - verilog/mem_pkg.sv
      - verilog/set_ram.sv
      - verilog/cache_way.sv
      - verilog/cache_controller.sv
      - verilog/main_memory.sv
      - verilog/cache_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/cache_tb.sv
